// File: design/adaptive_equalizer.sv
// Top level of the 11-tap LMS adaptive equalizer for recovered flux samples
// Connects the FIR datapath, coefficient bank, LMS update and error power meter
`timescale 1ns/10ps

module adaptive_equalizer
    import eq_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    // Sample stream with its ideal reference
    input  sample_t    data_in,
    input  sample_t    reference_in,
    input  logic       data_valid,

    // Adaptation control
    input  logic       training_mode,
    input  step_t      step_size,
    input  leak_t      leakage,

    // Host coefficient access
    input  logic       coef_read,
    input  logic       coef_write,
    input  coef_addr_t coef_addr,
    input  coef_t      coef_wdata,

    output sample_t    data_out,
    output logic       data_out_valid,
    output sample_t    current_error,
    output coef_t      coef_rdata,
    output power_t     error_power
);

    // ==============================
    // Internal nets
    // ==============================
    tap_vec_t  taps;
    coef_vec_t coefs;
    coef_vec_t next_coefs;
    logic      update_strobe;
    logic      error_valid;

    // Filter, also the source of the error
    fir_datapath u_fir_datapath (
        .clk            (clk),
        .reset_n        (reset_n),
        .data_in        (data_in),
        .reference_in   (reference_in),
        .data_valid     (data_valid),
        .coefs          (coefs),
        .taps           (taps),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .error          (current_error),
        .error_valid    (error_valid)
    );

    // Coefficient storage
    coef_bank u_coef_bank (
        .clk           (clk),
        .reset_n       (reset_n),
        .coef_write    (coef_write),
        .coef_read     (coef_read),
        .coef_addr     (coef_addr),
        .coef_wdata    (coef_wdata),
        .next_coefs    (next_coefs),
        .update_strobe (update_strobe),
        .coefs         (coefs),
        .coef_rdata    (coef_rdata)
    );

    // Adaptation
    lms_update u_lms_update (
        .clk           (clk),
        .reset_n       (reset_n),
        .taps          (taps),
        .coefs         (coefs),
        .error         (current_error),
        .error_valid   (error_valid),
        .training_mode (training_mode),
        .step_size     (step_size),
        .leakage       (leakage),
        .next_coefs    (next_coefs),
        .update_strobe (update_strobe)
    );

    // MSE estimate
    error_power_meter u_error_power_meter (
        .clk         (clk),
        .reset_n     (reset_n),
        .error       (current_error),
        .error_valid (error_valid),
        .error_power (error_power)
    );

endmodule

// File: design/coef_bank.sv
// Coefficient storage for the equalizer taps
// Adaptive updates take priority over host writes; host reads are registered
`timescale 1ns/10ps

module coef_bank
    import eq_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       coef_write,
    input  logic       coef_read,
    input  coef_addr_t coef_addr,
    input  coef_t      coef_wdata,
    input  coef_vec_t  next_coefs,
    input  logic       update_strobe,
    output coef_vec_t  coefs,
    output coef_t      coef_rdata
);

    // Addresses 11..15 do not map to a tap
    logic addr_in_range;

    assign addr_in_range = (coef_addr < coef_addr_t'(NUM_TAPS));

    // ==============================
    // Storage and write port
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            // Identity filter, center tap at one half
            for (int i = 0; i < NUM_TAPS; i++) begin
                if (i == CENTER_TAP) begin
                    coefs[i*COEF_WIDTH +: COEF_WIDTH] <= COEF_HALF;
                end else begin
                    coefs[i*COEF_WIDTH +: COEF_WIDTH] <= '0;
                end
            end
        end else if (update_strobe) begin
            // Whole set replaced at once, a host write on this edge is lost
            coefs <= next_coefs;
        end else if (coef_write && addr_in_range) begin
            coefs[coef_addr*COEF_WIDTH +: COEF_WIDTH] <= coef_wdata;
        end
    end

    // ==============================
    // Read port
    // ==============================
    // Out-of-range reads leave the last value in place
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            coef_rdata <= '0;
        end else if (coef_read && addr_in_range) begin
            coef_rdata <= coefs[coef_addr*COEF_WIDTH +: COEF_WIDTH];
        end
    end

endmodule

// File: design/eq_pkg.sv
// Widths, constants and vector types shared by the LMS equalizer
// Each RTL module pulls these in with a wildcard import
package eq_pkg;

    // ==============================
    // Sizes and fixed-point formats
    // ==============================
    localparam int DATA_WIDTH  = 12;
    localparam int COEF_WIDTH  = 16;
    localparam int NUM_TAPS    = 11;
    localparam int CENTER_TAP  = 5;
    // Q1.15 coefficients
    localparam int COEF_FRAC   = 15;

    // Full-precision FIR product and adder-tree widths
    localparam int PROD_WIDTH  = DATA_WIDTH + COEF_WIDTH;
    localparam int SUM_WIDTH   = PROD_WIDTH + 4;
    // Adder tree node counts, 11 -> 6 -> 3 -> 1
    localparam int TREE_L1     = (NUM_TAPS + 1) / 2;
    localparam int TREE_L2     = TREE_L1 / 2;
    // Sample to output, in clock edges
    localparam int FIR_LATENCY = 5;

    // ==============================
    // Adaptation
    // ==============================
    localparam int MU_SHIFT        = 12;
    localparam int LEAK_SHIFT      = 8;
    // error*tap*step, step widened by a zero sign bit
    localparam int GRAD_WIDTH      = 2 * DATA_WIDTH + 9;
    localparam int LEAK_PROD_WIDTH = COEF_WIDTH + 9;

    // Error power estimate
    localparam int POWER_WINDOW    = 256;
    localparam int POWER_SHIFT     = 12;
    localparam int POWER_ACC_WIDTH = 28;
    localparam int POWER_CNT_WIDTH = $clog2(POWER_WINDOW);

    // ==============================
    // Types
    // ==============================
    typedef logic signed [DATA_WIDTH-1:0]     sample_t;
    typedef logic signed [COEF_WIDTH-1:0]     coef_t;
    typedef logic [3:0]                       coef_addr_t;
    typedef logic [7:0]                       step_t;
    typedef logic [7:0]                       leak_t;
    typedef logic [15:0]                      power_t;
    // Flat vectors, entry i sits at bits [i*W +: W]
    typedef logic [NUM_TAPS*DATA_WIDTH-1:0]   tap_vec_t;
    typedef logic [NUM_TAPS*COEF_WIDTH-1:0]   coef_vec_t;

    // Identity filter center tap, 0.5
    localparam coef_t COEF_HALF = 16'h4000;

endpackage

// File: design/error_power_meter.sv
// Error power estimate: sum of squared errors over a 256-sample window
// The scaled sum is published at the end of each window
`timescale 1ns/10ps

module error_power_meter
    import eq_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  sample_t error,
    input  logic    error_valid,
    output power_t  error_power
);

    // Square is never negative, so the top bit stays clear
    logic signed [2*DATA_WIDTH-1:0] err_sq;
    logic [POWER_ACC_WIDTH-1:0]     acc;
    logic [POWER_ACC_WIDTH-1:0]     acc_next;
    logic [POWER_CNT_WIDTH-1:0]     win_count;

    assign err_sq   = error * error;
    assign acc_next = acc + {{(POWER_ACC_WIDTH-2*DATA_WIDTH){1'b0}}, err_sq};

    // ==============================
    // Window accumulate and publish
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc         <= '0;
            win_count   <= '0;
            error_power <= '0;
        end else if (error_valid) begin
            if (win_count == POWER_CNT_WIDTH'(POWER_WINDOW - 1)) begin
                // Last sample of the window is part of the estimate
                error_power <= power_t'(acc_next >> POWER_SHIFT);
                acc         <= '0;
                win_count   <= '0;
            end else begin
                acc       <= acc_next;
                win_count <= win_count + 1'b1;
            end
        end
    end

endmodule

// File: design/fir_datapath.sv
// FIR datapath of the equalizer: sample delay line, product and adder-tree pipeline
// Also carries the reference alongside so the error lands with data_out
`timescale 1ns/10ps

module fir_datapath
    import eq_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  sample_t   data_in,
    input  sample_t   reference_in,
    input  logic      data_valid,
    input  coef_vec_t coefs,
    output tap_vec_t  taps,
    output sample_t   data_out,
    output logic      data_out_valid,
    output sample_t   error,
    output logic      error_valid
);

    // Pipeline registers
    logic signed [PROD_WIDTH-1:0] prod [NUM_TAPS];
    logic signed [SUM_WIDTH-1:0]  sum_l1 [TREE_L1];
    logic signed [SUM_WIDTH-1:0]  sum_l2 [TREE_L2];
    logic signed [SUM_WIDTH-1:0]  sum_l3;

    // Valid flag and reference, one stage per datapath register
    logic [FIR_LATENCY-1:0] valid_pipe;
    sample_t                ref_pipe [FIR_LATENCY];

    // Scaled filter result, feeds both output and error
    sample_t equalized;

    // ==============================
    // Delay line
    // ==============================
    // Entry 0 holds the newest sample
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            taps <= '0;
        end else if (data_valid) begin
            taps <= {taps[(NUM_TAPS-1)*DATA_WIDTH-1:0], data_in};
        end
    end

    // ==============================
    // Products and adder tree
    // ==============================
    // Products use the coefficients as they are on this edge
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_TAPS; i++) begin
            prod[i] <= sample_t'(taps[i*DATA_WIDTH +: DATA_WIDTH])
                     * coef_t'(coefs[i*COEF_WIDTH +: COEF_WIDTH]);
        end
    end

    // Level one, pairs of products plus the odd last tap
    always_ff @(posedge clk) begin
        for (int j = 0; j < NUM_TAPS / 2; j++) begin
            sum_l1[j] <= prod[2*j] + prod[2*j+1];
        end
        sum_l1[TREE_L1-1] <= prod[NUM_TAPS-1];
    end

    // Level two, pairs of level-one sums
    always_ff @(posedge clk) begin
        for (int j = 0; j < TREE_L2; j++) begin
            sum_l2[j] <= sum_l1[2*j] + sum_l1[2*j+1];
        end
    end

    // Level three, the remaining three terms in one add
    always_ff @(posedge clk) begin
        logic signed [SUM_WIDTH-1:0] total;
        total = '0;
        for (int j = 0; j < TREE_L2; j++) begin
            total = total + sum_l2[j];
        end
        sum_l3 <= total;
    end

    // Drop the Q1.15 fraction, keep the low 12 bits
    assign equalized = sample_t'(sum_l3 >>> COEF_FRAC);

    // ==============================
    // Valid and reference alignment
    // ==============================
    // Bit k is high after edge k of a sample
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[FIR_LATENCY-2:0], data_valid};
        end
    end

    // Reference captured with its sample, then shifted every cycle
    always_ff @(posedge clk) begin
        if (data_valid) begin
            ref_pipe[0] <= reference_in;
        end
        for (int k = 1; k < FIR_LATENCY; k++) begin
            ref_pipe[k] <= ref_pipe[k-1];
        end
    end

    // ==============================
    // Output and error
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_out       <= '0;
            data_out_valid <= 1'b0;
            error          <= '0;
            error_valid    <= 1'b0;
        end else begin
            data_out_valid <= valid_pipe[FIR_LATENCY-1];
            // Same pulse, separate name for the adaptation side
            error_valid    <= valid_pipe[FIR_LATENCY-1];
            if (valid_pipe[FIR_LATENCY-1]) begin
                data_out <= equalized;
                // Reference minus output, wraps at 12 bits
                error    <= ref_pipe[FIR_LATENCY-1] - equalized;
            end
        end
    end

endmodule

// File: design/lms_update.sv
// Leaky LMS coefficient update for the equalizer
// Produces the next coefficient set one cycle after the gradient products are taken
`timescale 1ns/10ps

module lms_update
    import eq_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  tap_vec_t  taps,
    input  coef_vec_t coefs,
    input  sample_t   error,
    input  logic      error_valid,
    input  logic      training_mode,
    input  step_t     step_size,
    input  leak_t     leakage,
    output coef_vec_t next_coefs,
    output logic      update_strobe
);

    // Stage one results
    logic signed [2*DATA_WIDTH-1:0]    err_tap [NUM_TAPS];

    // Stage two terms
    logic signed [GRAD_WIDTH-1:0]      grad_full [NUM_TAPS];
    logic signed [LEAK_PROD_WIDTH-1:0] leak_full [NUM_TAPS];
    coef_t                             grad_term [NUM_TAPS];
    coef_t                             leak_term [NUM_TAPS];

    // Adapt only on a fresh error while training
    logic adapt;

    assign adapt = error_valid && training_mode;

    // ==============================
    // Stage one, error times tap
    // ==============================
    // Taps still hold the sample history that produced this error
    always_ff @(posedge clk) begin
        if (adapt) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                err_tap[i] <= error * sample_t'(taps[i*DATA_WIDTH +: DATA_WIDTH]);
            end
        end
    end

    // One-cycle load pulse toward the coefficient bank
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            update_strobe <= 1'b0;
        end else begin
            update_strobe <= adapt;
        end
    end

    // ==============================
    // Stage two, step and leakage
    // ==============================
    // Result is taken by the coefficient bank on the strobe edge
    always_comb begin
        next_coefs = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            // mu * e * x with mu = step_size / 2^12
            grad_full[i] = err_tap[i] * $signed({1'b0, step_size});
            grad_term[i] = coef_t'(grad_full[i] >>> MU_SHIFT);
            // Pull toward zero by leakage / 256 of the current value
            leak_full[i] = coef_t'(coefs[i*COEF_WIDTH +: COEF_WIDTH])
                         * $signed({1'b0, leakage});
            leak_term[i] = coef_t'(leak_full[i] >>> LEAK_SHIFT);
            // 16-bit wrap, no saturation
            next_coefs[i*COEF_WIDTH +: COEF_WIDTH] =
                coef_t'(coefs[i*COEF_WIDTH +: COEF_WIDTH]) + grad_term[i] - leak_term[i];
        end
    end

endmodule

// File: verification/tb_adaptive_equalizer.sv
// Directed testbench for the LMS adaptive equalizer
// Keeps its own delay line, coefficient and error-power model and checks the DUT against it
`timescale 1ns/10ps

module tb_adaptive_equalizer
    import eq_pkg::*;
();

    localparam int unsigned SEED = 32'h47ce237a;
    // Well above the few hundred cycles that the tests need
    localparam int TIMEOUT_CYCLES = 4000;
    // Driving edge then sampling edge then FIR_LATENCY more edges
    localparam int OUT_OFFSET = FIR_LATENCY + 2;

    logic       clk;
    logic       reset_n;
    sample_t    data_in;
    sample_t    reference_in;
    logic       data_valid;
    logic       training_mode;
    step_t      step_size;
    leak_t      leakage;
    logic       coef_read;
    logic       coef_write;
    coef_addr_t coef_addr;
    coef_t      coef_wdata;
    sample_t    data_out;
    logic       data_out_valid;
    sample_t    current_error;
    coef_t      coef_rdata;
    power_t     error_power;

    // Model state
    sample_t                    model_taps [NUM_TAPS];
    coef_t                      model_coef [NUM_TAPS];
    logic [POWER_ACC_WIDTH-1:0] model_acc;
    int                         model_cnt;
    power_t                     exp_power;
    int                         cycle_count;

    // Samples in flight with the oldest first
    sample_t exp_out_q [$];
    sample_t exp_err_q [$];
    int      exp_cycle_q [$];

    adaptive_equalizer UUT (
        .clk            (clk),
        .reset_n        (reset_n),
        .data_in        (data_in),
        .reference_in   (reference_in),
        .data_valid     (data_valid),
        .training_mode  (training_mode),
        .step_size      (step_size),
        .leakage        (leakage),
        .coef_read      (coef_read),
        .coef_write     (coef_write),
        .coef_addr      (coef_addr),
        .coef_wdata     (coef_wdata),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .current_error  (current_error),
        .coef_rdata     (coef_rdata),
        .error_power    (error_power)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==============================
    // Failure reporting and compares
    // ==============================
    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_sample(input string what, input sample_t got, input sample_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("FAIL %0t: %s is %0d, expected %0d",
                                        $time, what, got, expected));
        end
    endtask

    task automatic check_coef(input string what, input coef_t got, input coef_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("FAIL %0t: %s is %0d, expected %0d",
                                        $time, what, got, expected));
        end
    endtask

    task automatic check_power(input string what, input power_t got, input power_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("FAIL %0t: %s is %0d, expected %0d",
                                        $time, what, got, expected));
        end
    endtask

    // Cycle counter doubles as the run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure("Timeout: the tests did not finish within the cycle limit");
        end
    end

    // Output monitor samples mid-cycle where outputs are stable
    always @(negedge clk) begin
        if (reset_n && data_out_valid) begin
            if (exp_out_q.size() == 0) begin
                stop_with_failure("data_out_valid pulsed with no sample in flight");
            end else begin
                if (cycle_count != exp_cycle_q[0]) begin
                    stop_with_failure($sformatf("FAIL %0t: output in cycle %0d, expected %0d",
                                                $time, cycle_count, exp_cycle_q[0]));
                end
                check_sample("data_out", data_out, exp_out_q[0]);
                check_sample("current_error", current_error, exp_err_q[0]);
                void'(exp_out_q.pop_front());
                void'(exp_err_q.pop_front());
                void'(exp_cycle_q.pop_front());
            end
        end else if (exp_cycle_q.size() != 0 && cycle_count > exp_cycle_q[0]) begin
            stop_with_failure("A sample was taken but its data_out_valid pulse never came");
        end
    end

    // ==============================
    // Reference model
    // ==============================
    // Tap-weighted sum with the Q1.15 fraction dropped and the low 12 bits kept
    function automatic sample_t fir_model();
        longint acc;
        acc = 0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            acc = acc + longint'(model_taps[i]) * longint'(model_coef[i]);
        end
        return sample_t'(acc >>> COEF_FRAC);
    endfunction

    // Squared error into the 28-bit window sum
    task automatic record_error(input sample_t e);
        longint sq;
        sq = longint'(e) * longint'(e);
        model_acc = model_acc + POWER_ACC_WIDTH'(sq);
        model_cnt = model_cnt + 1;
        if (model_cnt == POWER_WINDOW) begin
            exp_power = power_t'(model_acc >> POWER_SHIFT);
            model_acc = '0;
            model_cnt = 0;
        end
    endtask

    // Leaky LMS step c + (e*x*mu >>> 12) - (c*leak >>> 8) with each term cut to 16 bits
    task automatic apply_lms_model(input sample_t e, input step_t s, input leak_t l);
        longint grad;
        longint leak_prod;
        longint step_val;
        longint leak_val;
        step_val = s;
        leak_val = l;
        for (int i = 0; i < NUM_TAPS; i++) begin
            grad = longint'(e) * longint'(model_taps[i]) * step_val;
            leak_prod = longint'(model_coef[i]) * leak_val;
            model_coef[i] = model_coef[i] + coef_t'(grad >>> MU_SHIFT)
                          - coef_t'(leak_prod >>> LEAK_SHIFT);
        end
    endtask

    // ==============================
    // Bus tasks
    // ==============================
    // One sample per call so back-to-back calls give one per cycle
    task automatic drive_sample(input sample_t x, input sample_t r, output sample_t e);
        sample_t y;
        @(posedge clk);
        data_in      <= x;
        reference_in <= r;
        data_valid   <= 1'b1;
        // Counter still holds its pre-edge value here
        exp_cycle_q.push_back(cycle_count + OUT_OFFSET);
        for (int i = NUM_TAPS - 1; i > 0; i--) begin
            model_taps[i] = model_taps[i-1];
        end
        model_taps[0] = x;
        y = fir_model();
        e = r - y;
        exp_out_q.push_back(y);
        exp_err_q.push_back(e);
        record_error(e);
    endtask

    task automatic end_stream();
        @(posedge clk);
        data_valid <= 1'b0;
    endtask

    task automatic wait_outputs();
        while (exp_out_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic write_coef(input coef_addr_t a, input coef_t value);
        @(posedge clk);
        coef_write <= 1'b1;
        coef_addr  <= a;
        coef_wdata <= value;
        @(posedge clk);
        coef_write <= 1'b0;
        if (a < NUM_TAPS) begin
            model_coef[a] = value;
        end
    endtask

    task automatic read_coef(input coef_addr_t a, input coef_t expected);
        @(posedge clk);
        coef_read <= 1'b1;
        coef_addr <= a;
        @(posedge clk);
        coef_read <= 1'b0;
        @(negedge clk);
        check_coef($sformatf("coef_rdata at address %0d", a), coef_rdata, expected);
    endtask

    task automatic stream_random(input int count);
        sample_t e;
        repeat (count) begin
            drive_sample(sample_t'($urandom), sample_t'($urandom), e);
        end
        end_stream();
        wait_outputs();
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic test_reset_state();
        check_coef("coef_rdata after reset", coef_rdata, '0);
        check_power("error_power after reset", error_power, '0);
        for (int i = 0; i < NUM_TAPS; i++) begin
            read_coef(coef_addr_t'(i), model_coef[i]);
        end
    endtask

    // Monitor checks identity filtering, latency and error
    task automatic test_identity_stream();
        stream_random(40);
    endtask

    task automatic test_coef_access();
        for (int i = 0; i < NUM_TAPS; i++) begin
            write_coef(coef_addr_t'(i), coef_t'($urandom));
        end
        for (int i = 0; i < NUM_TAPS; i++) begin
            read_coef(coef_addr_t'(i), model_coef[i]);
        end
        // Address 12 maps to no tap so rdata keeps the last tap read
        write_coef(4'd12, coef_t'($urandom));
        read_coef(4'd12, model_coef[NUM_TAPS-1]);
        for (int i = 0; i < NUM_TAPS; i++) begin
            read_coef(coef_addr_t'(i), model_coef[i]);
        end
        stream_random(24);
    endtask

    task automatic test_lms_update();
        step_t   s;
        leak_t   l;
        sample_t e;
        repeat (6) begin
            s = step_t'($urandom);
            l = leak_t'($urandom_range(0, 31));
            @(posedge clk);
            training_mode <= 1'b1;
            step_size     <= s;
            leakage       <= l;
            // Output of an isolated sample uses the coefficients before the update
            drive_sample(sample_t'($urandom), sample_t'($urandom), e);
            end_stream();
            apply_lms_model(e, s, l);
            wait_outputs();
            // Update lands two edges after the output
            repeat (3) @(posedge clk);
            for (int i = 0; i < NUM_TAPS; i++) begin
                read_coef(coef_addr_t'(i), model_coef[i]);
            end
        end
        @(posedge clk);
        training_mode <= 1'b0;
    endtask

    task automatic test_error_power();
        stream_random(POWER_WINDOW);
        @(negedge clk);
        check_power("error_power", error_power, exp_power);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        void'($urandom(SEED));
        cycle_count   = 0;
        reset_n       = 1'b0;
        data_in       = '0;
        reference_in  = '0;
        data_valid    = 1'b0;
        training_mode = 1'b0;
        step_size     = '0;
        leakage       = '0;
        coef_read     = 1'b0;
        coef_write    = 1'b0;
        coef_addr     = '0;
        coef_wdata    = '0;
        // Zero delay line and identity filter at 0.5
        for (int i = 0; i < NUM_TAPS; i++) begin
            model_taps[i] = '0;
            model_coef[i] = (i == CENTER_TAP) ? COEF_HALF : '0;
        end
        model_acc = '0;
        model_cnt = 0;
        exp_power = '0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        test_reset_state();
        test_identity_stream();
        test_coef_access();
        test_lms_update();
        test_error_power();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: vlog.f
design/eq_pkg.sv
design/fir_datapath.sv
design/coef_bank.sv
design/lms_update.sv
design/error_power_meter.sv
design/adaptive_equalizer.sv
verification/tb_adaptive_equalizer.sv
